/* verilog/b1_cfg.svh */
`ifndef B1_CFG_SVH
`define B1_CFG_SVH

// Line buffer size, one entry per pixel of a line
`define B1_LB_DEPTH 256

// Fix tile byte delay, matches the tile fetch latency
`define B1_FIX_STAGES 3

// Top two CPU address bits of the palette RAM window
// 01 selects the $400000 area
`define B1_CPU_PAL_PAGE 2'b01

`endif

/* verilog/b1Pkg.sv */
`default_nettype none

package b1Pkg;

	// Palette RAM address, palette number on top of color
	typedef logic [11:0] palAddr_t;

	// Sprite palette number from the pixel bus
	typedef logic [7:0] sprPal_t;

	// Fix palette number, upper 4 bits of palAddr_t forced to zero
	typedef logic [3:0] fixPal_t;

	// Color index in a palette, 0 is transparent
	typedef logic [3:0] color_t;

	// Pixel position on the line
	typedef logic [7:0] xPos_t;

endpackage

`default_nettype wire

/* verilog/pixelIf.sv */
`default_nettype none
`timescale 1ns/1ps

interface pixelIf import b1Pkg::*; ();

	fixPal_t fixPal;		// From fix palette stage B
	color_t fixColor;		// Selected fix nibble
	sprPal_t sprPal;		// Line buffer output entry
	color_t sprColor;

	// Decode side, fix layer only
	modport fixSrc (
		output fixPal,
		output fixColor
	);

	// Line buffer side
	modport sprSrc (
		output sprPal,
		output sprColor
	);

	// Palette address mux reads everything
	modport mixer (
		input fixPal,
		input fixColor,
		input sprPal,
		input sprColor
	);

endinterface

`default_nettype wire

/* verilog/pixelBusDecode.sv */
`default_nettype none
`timescale 1ns/1ps
`include "b1_cfg.svh"

module pixelBusDecode import b1Pkg::*; (
	input wire logic CLK_1MB,
	input wire logic reset,
	input wire logic [23:0] pBus,		// Palette numbers and sprite X
	input wire logic [7:0] fixData,	// Two fix pixels per byte
	input wire logic pck1,				// Sprite attribute strobe
	input wire logic pck2,				// Fix attribute strobe
	input wire logic s1h1,				// Even/odd fix pixel
	output logic xLoad,
	output xPos_t sprX,
	output sprPal_t latchedPal,
	pixelIf.fixSrc pix
);

	fixPal_t fixPalA;		// Newest pck2 value
	fixPal_t fixPalB;		// Previous one, goes out
	logic [7:0] fixPipe [`B1_FIX_STAGES];

	// Sprite attributes, xLoad one cycle behind the strobe
	always_ff @(posedge CLK_1MB)
	begin
		if (reset)
		begin
			xLoad <= 1'b0;
			sprX <= '0;
			latchedPal <= '0;
		end
		else
		begin
			xLoad <= pck1;
			if (pck1)
			begin
				latchedPal <= pBus[23:16];
				sprX <= pBus[15:8];
			end
		end
	end

	// Fix palette, two deep
	always_ff @(posedge CLK_1MB)
	begin
		if (reset)
		begin
			fixPalA <= '0;
			fixPalB <= '0;
		end
		else if (pck2)
		begin
			fixPalB <= fixPalA;
			fixPalA <= pBus[19:16];
		end
	end

	// Tile byte delay line, free running
	always_ff @(posedge CLK_1MB)
	begin
		if (reset)
		begin
			for (int i = 0; i < `B1_FIX_STAGES; i++)
				fixPipe[i] <= '0;
		end
		else
		begin
			fixPipe[0] <= fixData;
			for (int i = 1; i < `B1_FIX_STAGES; i++)
				fixPipe[i] <= fixPipe[i - 1];
		end
	end

	assign pix.fixPal = fixPalB;
	// High nibble on s1h1, stage C only
	assign pix.fixColor = s1h1 ? fixPipe[`B1_FIX_STAGES - 1][7:4]
		: fixPipe[`B1_FIX_STAGES - 1][3:0];

	// Both strobes share the pixel bus, so they can never overlap
	pckExclusive: assert property (@(posedge CLK_1MB) disable iff (reset)
		!(pck1 && pck2));

endmodule

`default_nettype wire

/* verilog/spriteLineBuffer.sv */
`default_nettype none
`timescale 1ns/1ps
`include "b1_cfg.svh"

module spriteLineBuffer import b1Pkg::*; (
	input wire logic CLK_1MB,
	input wire logic reset,
	input wire logic xLoad,			// Reload write counter
	input wire xPos_t sprX,
	input wire sprPal_t latchedPal,
	input wire color_t gad,			// Pixel at counter
	input wire color_t gbd,			// Pixel next to it
	input wire logic lbWrite,
	input wire logic hFlip,			// Write right to left
	input wire logic lineFlip,		// End of line swaps buffers
	pixelIf.sprSrc pix
);

	// Each entry is {palette, color}
	palAddr_t lbMem [2][`B1_LB_DEPTH];
	palAddr_t sprOut;					// Entry read last cycle

	logic wrBank;						// Buffer being filled
	logic dispBank;					// Buffer being shown
	xPos_t wrCnt;
	xPos_t wrNext;						// Address for gbd
	xPos_t wrStep;						// Counter after the pair
	xPos_t rdCnt;

	assign dispBank = ~wrBank;

	// Up or down depending on flip
	assign wrNext = hFlip ? xPos_t'(wrCnt - 8'd1) : xPos_t'(wrCnt + 8'd1);
	assign wrStep = hFlip ? xPos_t'(wrCnt - 8'd2) : xPos_t'(wrCnt + 8'd2);

	// Bank select and counters
	always_ff @(posedge CLK_1MB)
	begin
		if (reset)
		begin
			wrBank <= 1'b0;
			wrCnt <= '0;
			rdCnt <= '0;
		end
		else
		begin
			if (lineFlip)
				wrBank <= ~wrBank;

			if (xLoad)
				wrCnt <= sprX;				// Sprite start
			else if (lbWrite)
				wrCnt <= wrStep;

			if (lineFlip)
				rdCnt <= '0;				// Restart display at left edge
			else if (rdCnt == xPos_t'(`B1_LB_DEPTH - 1))
				rdCnt <= '0;
			else
				rdCnt <= rdCnt + 8'd1;
		end
	end

	// Write side and read/clear side never share a bank
	always_ff @(posedge CLK_1MB)
	begin
		if (reset)
		begin
			sprOut <= '0;
			for (int b = 0; b < 2; b++)
			begin
				for (int i = 0; i < `B1_LB_DEPTH; i++)
					lbMem[b][i] <= '0;		// All transparent
			end
		end
		else
		begin
			if (lbWrite)
			begin
				// Color 0 keeps what an earlier sprite left
				if (gad != '0)
					lbMem[wrBank][wrCnt] <= {latchedPal, gad};
				if (gbd != '0)
					lbMem[wrBank][wrNext] <= {latchedPal, gbd};
			end

			if (!lineFlip)
			begin
				sprOut <= lbMem[dispBank][rdCnt];
				lbMem[dispBank][rdCnt] <= '0;	// Ready for the next fill
			end
		end
	end

	assign pix.sprPal = sprOut[11:4];
	assign pix.sprColor = sprOut[3:0];

	// Counter load and pair write would fight over wrCnt
	loadWriteApart: assert property (@(posedge CLK_1MB) disable iff (reset)
		!(lbWrite && xLoad));

endmodule

`default_nettype wire

/* verilog/paletteMixer.sv */
`default_nettype none
`timescale 1ns/1ps
`include "b1_cfg.svh"

module paletteMixer import b1Pkg::*; (
	input wire logic CLK_1MB,
	input wire logic reset,
	input wire logic chbl,				// Blanking forces zero
	input wire logic nAs,				// CPU address strobe
	input wire logic [1:0] cpuAddrHi,
	input wire palAddr_t cpuAddr,
	output palAddr_t pa,
	pixelIf.mixer pix
);

	logic cpuHit;
	logic fixOpaque;
	palAddr_t paNext;

	// Palette RAM window decode
	assign cpuHit = !nAs && (cpuAddrHi == `B1_CPU_PAL_PAGE);
	assign fixOpaque = (pix.fixColor != '0);

	// Priority from CPU down to sprite
	always_comb
	begin
		if (cpuHit)
			paNext = cpuAddr;
		else if (chbl)
			paNext = '0;
		else if (fixOpaque)
			paNext = {4'b0000, pix.fixPal, pix.fixColor};	// Fix palettes are 0 to 15
		else
			paNext = {pix.sprPal, pix.sprColor};
	end

	// Palette address latch
	always_ff @(posedge CLK_1MB)
	begin
		if (reset)
			pa <= '0;
		else
			pa <= paNext;
	end

	// Blanking without a CPU palette access lands as zero on the next cycle
	blankZero: assert property (@(posedge CLK_1MB) disable iff (reset)
		(chbl && (nAs || cpuAddrHi != `B1_CPU_PAL_PAGE)) |=> (pa == '0));

endmodule

`default_nettype wire

/* verilog/neoB1.sv */
`default_nettype none
`timescale 1ns/1ps

module neoB1 import b1Pkg::*; (
	input wire logic CLK_1MB,
	input wire logic reset,
	input wire logic [23:0] pBus,
	input wire logic [7:0] fixData,
	input wire logic pck1,
	input wire logic pck2,
	input wire logic s1h1,
	input wire color_t gad,
	input wire color_t gbd,
	input wire logic lbWrite,
	input wire logic hFlip,
	input wire logic lineFlip,
	input wire logic chbl,
	input wire logic nAs,
	input wire logic [1:0] cpuAddrHi,
	input wire palAddr_t cpuAddr,
	output palAddr_t pa
);

	// Decode to line buffer
	logic xLoad;
	xPos_t sprX;
	sprPal_t latchedPal;

	pixelIf pix ();		// Fix and sprite pixels to the mixer

	pixelBusDecode uDecode (
		.CLK_1MB		(CLK_1MB),
		.reset		(reset),
		.pBus			(pBus),
		.fixData		(fixData),
		.pck1			(pck1),
		.pck2			(pck2),
		.s1h1			(s1h1),
		.xLoad		(xLoad),
		.sprX			(sprX),
		.latchedPal	(latchedPal),
		.pix			(pix.fixSrc)
	);

	spriteLineBuffer uLineBuf (
		.CLK_1MB		(CLK_1MB),
		.reset		(reset),
		.xLoad		(xLoad),
		.sprX			(sprX),
		.latchedPal	(latchedPal),
		.gad			(gad),
		.gbd			(gbd),
		.lbWrite		(lbWrite),
		.hFlip		(hFlip),
		.lineFlip	(lineFlip),
		.pix			(pix.sprSrc)
	);

	paletteMixer uMixer (
		.CLK_1MB		(CLK_1MB),
		.reset		(reset),
		.chbl			(chbl),
		.nAs			(nAs),
		.cpuAddrHi	(cpuAddrHi),
		.cpuAddr		(cpuAddr),
		.pa			(pa),
		.pix			(pix.mixer)
	);

endmodule

`default_nettype wire

/* sim/tbNeoB1.sv */
`default_nettype none
`timescale 1ns/1ps
`include "b1_cfg.svh"

module tbNeoB1 import b1Pkg::*; ();

	localparam int MaxCycles = 3000;	// All tests take about 1150 cycles
	localparam int ScanMax = 258;		// Two lead cycles plus a full line

	logic CLK_1MB = 1'b0;
	logic reset, pck1, pck2, s1h1, lbWrite, hFlip, lineFlip, chbl, nAs;
	logic [23:0] pBus;
	logic [7:0] fixData;
	logic [1:0] cpuAddrHi;
	color_t gad, gbd;
	palAddr_t cpuAddr, pa;

	integer seed;
	int cycles = 0;
	int checks = 0;
	int errors = 0;
	fixPal_t palNew = '0;				// Last pck2 value
	fixPal_t palOld = '0;				// The one before it shows on fix pixels
	palAddr_t expLine [`B1_LB_DEPTH];	// Expected content of the buffer being filled

	// Stimulus per scan cycle
	logic [7:0] scanFix [ScanMax];
	logic scanSel [ScanMax];
	logic [3:0] scanCtl [ScanMax];		// {chbl, nAs, cpuAddrHi}
	palAddr_t scanCpu [ScanMax];

	neoB1 dut_i (.*);

	always #5 CLK_1MB = ~CLK_1MB;

	always @(posedge CLK_1MB)
	begin
		cycles++;
		if (cycles >= MaxCycles)
		begin
			$display("Timeout after %0d cycles with %0d errors", cycles, errors);
			$display("Result: FAILED");
			$finish;
		end
	end

	// Drive point 1 ns past the edge
	task automatic tick();
		@(posedge CLK_1MB);
		#1;
	endtask

	task automatic checkPa(input palAddr_t expPa, input string where);
		checks++;
		if (pa !== expPa)
		begin
			errors++;
			$display("Mismatch pa at %s: got 0x%h, expected 0x%h", where, pa, expPa);
		end
	endtask

	task automatic strobeFix(input fixPal_t pal);
		pBus = {4'h0, pal, 16'h0000};
		pck2 = 1'b1;
		palOld = palNew;					// Two deep so the older one goes out
		palNew = pal;
		tick();
		pck2 = 1'b0;
	endtask

	task automatic emptyLine();
		for (int i = 0; i < `B1_LB_DEPTH; i++)
			expLine[i] = '0;
	endtask

	// Transparent fix with no blanking and nAs high
	task automatic idleScan();
		for (int s = 0; s < ScanMax; s++)
		begin
			scanFix[s] = 8'h00;
			scanSel[s] = 1'b0;
			scanCtl[s] = 4'b0100;
			scanCpu[s] = 12'h000;
		end
	endtask

	// Sprite of pixel pairs from x
	// With gaps every odd gad and every even gbd is transparent
	task automatic writeSprite(input sprPal_t pal, input xPos_t x, input int pairs,
		input logic flip, input logic gaps);
		xPos_t pos;
		pBus = {pal, x, 8'h00};
		pck1 = 1'b1;
		tick();
		pck1 = 1'b0;
		tick();								// Counter holds x after this edge
		pos = x;
		hFlip = flip;
		lbWrite = 1'b1;
		for (int n = 0; n < pairs; n++)
		begin
			gad = (gaps && n[0]) ? 4'h0 : color_t'($random(seed)) | 4'h1;
			gbd = (gaps && !n[0]) ? 4'h0 : color_t'($random(seed)) | 4'h2;
			if (gad != 4'h0)
				expLine[pos] = {pal, gad};		// Color 0 keeps the older pixel
			if (gbd != 4'h0)
				expLine[flip ? xPos_t'(pos - 8'd1) : xPos_t'(pos + 8'd1)] = {pal, gbd};
			pos = flip ? xPos_t'(pos - 8'd2) : xPos_t'(pos + 8'd2);
			tick();
		end
		lbWrite = 1'b0;
		hFlip = 1'b0;
	endtask

	// Plays the scan arrays
	// pa at step s comes from the mixer edge before it
	task automatic runScan(input int n, input logic doFlip);
		palAddr_t expPa;
		logic [7:0] fixByte;
		logic [3:0] ctl;
		color_t nib;
		if (doFlip)
		begin
			lineFlip = 1'b1;
			tick();
			lineFlip = 1'b0;					// Read counter at 0 from here
		end
		for (int s = 0; s < n; s++)
		begin
			if (s >= 2)
			begin
				fixByte = (s >= 4) ? scanFix[s - 4] : 8'h00;	// Three stages plus pa
				nib = scanSel[s - 1] ? fixByte[7:4] : fixByte[3:0];
				ctl = scanCtl[s - 1];
				if (!ctl[2] && ctl[1:0] == `B1_CPU_PAL_PAGE)
					expPa = scanCpu[s - 1];
				else if (ctl[3])
					expPa = '0;
				else if (nib != 4'h0)
					expPa = {4'h0, palOld, nib};
				else
					expPa = expLine[s - 2];		// Entry X shows at step X + 2
				checkPa(expPa, $sformatf("scan step %0d", s));
			end
			fixData = scanFix[s];
			s1h1 = scanSel[s];
			{chbl, nAs, cpuAddrHi} = scanCtl[s];
			cpuAddr = scanCpu[s];
			tick();
		end
		fixData = 8'h00;
		{chbl, nAs, cpuAddrHi} = 4'b0100;
		repeat (4) tick();					// Flush fix delay line
		if (doFlip)
			emptyLine();					// Shown entries were cleared
	endtask

	task automatic fixPixels();
		strobeFix(4'h6);
		strobeFix(4'hB);
		idleScan();
		for (int s = 0; s < 24; s++)
		begin
			scanFix[s] = 8'($random(seed));
			scanSel[s] = s[0];				// s1h1 toggles each pixel
		end
		scanFix[3] = 8'h00;
		scanFix[9] = 8'hF0;					// Low nibble picked and transparent
		runScan(24, 1'b0);
	endtask

	task automatic spriteDisplay();
		writeSprite(8'h3C, 8'd100, 6, 1'b0, 1'b0);
		writeSprite(8'hA7, 8'd250, 4, 1'b0, 1'b0);	// Wraps past 255
		idleScan();
		runScan(ScanMax, 1'b1);
	endtask

	task automatic overlapFlip();
		writeSprite(8'h21, 8'd40, 8, 1'b0, 1'b0);	// X 40 to 55
		writeSprite(8'h94, 8'd50, 6, 1'b1, 1'b1);	// X 50 down to 39
		idleScan();
		runScan(ScanMax, 1'b1);
	endtask

	task automatic readClears();
		idleScan();
		runScan(ScanMax, 1'b1);
		runScan(ScanMax, 1'b1);				// Back to the bank read in overlapFlip
	endtask

	task automatic priorityOrder();
		writeSprite(8'h5A, 8'd0, 6, 1'b0, 1'b0);	// X 0 to 11
		idleScan();
		scanFix[2] = 8'h0C;					// Fix over sprite X 4
		scanFix[3] = 8'h30;
		scanCtl[7] = 4'b1100;				// Blank sprite X 6
		scanFix[5] = 8'h05;
		scanCtl[8] = 4'b1100;				// Blank over opaque fix
		scanFix[6] = 8'h0E;
		scanCtl[9] = {2'b10, `B1_CPU_PAL_PAGE};	// CPU over blanking and fix
		scanCpu[9] = 12'h7D3;
		scanCtl[11] = 4'b0010;				// Outside window
		scanCpu[11] = 12'hFFF;
		scanCtl[12] = {2'b01, `B1_CPU_PAL_PAGE};	// No strobe
		scanCpu[12] = 12'hEEE;
		runScan(16, 1'b1);
	endtask

	initial
	begin
		seed = 32'ha4940a93;
		reset = 1'b1;
		{pck1, pck2, s1h1, lbWrite, hFlip, lineFlip, chbl} = '0;
		nAs = 1'b1;
		pBus = '0;
		fixData = '0;
		gad = '0;
		gbd = '0;
		cpuAddrHi = '0;
		cpuAddr = '0;
		emptyLine();
		repeat (3) tick();
		reset = 1'b0;
		checkPa(12'h000, "reset");

		fixPixels();
		spriteDisplay();
		overlapFlip();
		readClears();
		priorityOrder();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+verilog
verilog/b1Pkg.sv
verilog/pixelIf.sv
verilog/pixelBusDecode.sv
verilog/spriteLineBuffer.sv
verilog/paletteMixer.sv
verilog/neoB1.sv
sim/tbNeoB1.sv

/* Bender.yml */
package:
  name: neo_b1

export_include_dirs:
  - verilog

sources:
  - verilog/b1Pkg.sv
  - verilog/pixelIf.sv
  - verilog/pixelBusDecode.sv
  - verilog/spriteLineBuffer.sv
  - verilog/paletteMixer.sv
  - verilog/neoB1.sv
  - target: simulation
    files:
      - sim/tbNeoB1.sv
